//--- verilog/axi_lite_pkg.sv
`default_nettype none

// Bus level definitions for the AXI4-Lite slave port
package axi_lite_pkg;

	// ----------------------------------------------------------------------
	// Data path widths
	// ----------------------------------------------------------------------

	// Width of one bus word
	localparam int data_width = 32;

	// One strobe per byte lane
	localparam int strb_width = data_width / 8;

	// Byte offset bits below the word index
	localparam int addr_lsb = 2;

	// One bus word
	typedef logic [data_width-1:0] word_t;

	// Byte lane enables of one write
	typedef logic [strb_width-1:0] strb_t;

	// ----------------------------------------------------------------------
	// Responses
	// ----------------------------------------------------------------------

	// Two bit response code on the B and R channels
	typedef logic [1:0] resp_t;

	// Normal access completed
	localparam resp_t resp_okay = 2'b00;

endpackage

`default_nettype wire

//--- verilog/debug_regs_pkg.sv
`default_nettype none

// Register map of the stream debugger control block
package debug_regs_pkg;

	// ----------------------------------------------------------------------
	// Map size
	// ----------------------------------------------------------------------

	// Eight words in the register window
	localparam int reg_count = 8;

	// Word index within the window
	typedef logic [$clog2(reg_count)-1:0] reg_index_t;

	// ----------------------------------------------------------------------
	// Word indices
	// ----------------------------------------------------------------------

	// Read-only status words fed by the stream monitor
	localparam reg_index_t idx_byte_count = 3'd0;
	localparam reg_index_t idx_tlast_count = 3'd1;
	localparam reg_index_t idx_last_tlast = 3'd2;

	// Scratch words start here and run to the end of the map
	localparam reg_index_t first_scratch = 3'd3;

endpackage

`default_nettype wire

//--- verilog/reg_write_if.sv
`timescale 1ns/1ps
`default_nettype none

// One accepted register write from the bus side to the register storage
interface reg_write_if;
	import axi_lite_pkg::*;
	import debug_regs_pkg::*;

	// High for exactly one clock per accepted write
	logic wr_en;

	// Target word and payload
	reg_index_t wr_index;
	word_t wr_data;
	strb_t wr_strb;

	// Write channel side
	modport source (output wr_en, output wr_index, output wr_data, output wr_strb);

	// Register bank side, sampled on the edge where wr_en is high
	modport sink (input wr_en, input wr_index, input wr_data, input wr_strb);

endinterface

`default_nettype wire

//--- verilog/axi_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

// AXI4-Lite write address, write data and write response handling
module axi_write_channel #(
	parameter int addr_width = 5
)
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,

	// Write address channel
	input logic [addr_width-1:0] awaddr,
	input logic awvalid,
	output logic awready,

	// Write data channel
	input axi_lite_pkg::word_t wdata,
	input axi_lite_pkg::strb_t wstrb,
	input logic wvalid,
	output logic wready,

	// Write response channel
	output axi_lite_pkg::resp_t bresp,
	output logic bvalid,
	input logic bready,

	// Accepted write towards the register bank
	reg_write_if.source wr
);
	import axi_lite_pkg::*;
	import debug_regs_pkg::*;

	// Number of address bits that select a word
	localparam int index_bits = $bits(reg_index_t);

	// Cleared on acceptance, set again once the response is taken
	logic aw_en;
	// Single cycle accept strobe
	logic ready_q;
	// Both channels valid while idle
	logic start;

	assign start = aw_en && awvalid && wvalid;

	// ----------------------------------------------------------------------
	// Handshake control
	// ----------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			aw_en <= 1'b1;
			ready_q <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			// Readies high for one cycle after both valids are seen
			ready_q <= start;
			if (start)
				aw_en <= 1'b0;
			else if (bvalid && bready)
				aw_en <= 1'b1;
			// Response raised as address and data handshakes complete
			if (ready_q)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Address and data are accepted together
	assign awready = ready_q;
	assign wready = ready_q;

	// Every write completes normally
	assign bresp = resp_okay;

	// ----------------------------------------------------------------------
	// Write payload towards the bank
	// ----------------------------------------------------------------------

	// Master holds address and data until the handshake, so latch at start
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (start)
		begin
			wr.wr_index <= awaddr[addr_lsb +: index_bits];
			wr.wr_data <= wdata;
			wr.wr_strb <= wstrb;
		end
	end

	// Bank updates on the edge that ends the ready cycle
	assign wr.wr_en = ready_q;

endmodule

`default_nettype wire

//--- verilog/debug_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

// Scratch register storage and read multiplexer of the debugger map
module debug_reg_bank
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,

	// Accepted writes from the write channel
	reg_write_if.sink wr,

	// Live status from the stream monitor
	input axi_lite_pkg::word_t byte_count,
	input axi_lite_pkg::word_t tlast_count,
	input axi_lite_pkg::word_t last_tlast,

	// Combinational read port
	input debug_regs_pkg::reg_index_t rd_index,
	output axi_lite_pkg::word_t rd_data
);
	import axi_lite_pkg::*;
	import debug_regs_pkg::*;

	// Only the scratch part of the map has storage
	word_t scratch [first_scratch:reg_count-1];

	// ----------------------------------------------------------------------
	// Scratch writes
	// ----------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int i = first_scratch; i < reg_count; i++)
				scratch[i] <= '0;
		end
		// Status indices are silently ignored
		else if (wr.wr_en && (wr.wr_index >= first_scratch))
		begin
			// Byte lane merge under the strobes
			for (int b = 0; b < strb_width; b++)
			begin
				if (wr.wr_strb[b])
					scratch[wr.wr_index][b*8 +: 8] <= wr.wr_data[b*8 +: 8];
			end
		end
	end

	// ----------------------------------------------------------------------
	// Read multiplexer
	// ----------------------------------------------------------------------

	always_comb
	begin
		case (rd_index)
			idx_byte_count: rd_data = byte_count;
			idx_tlast_count: rd_data = tlast_count;
			idx_last_tlast: rd_data = last_tlast;
			// Anything else is a scratch word
			default: rd_data = scratch[rd_index];
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/axi_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

// AXI4-Lite read address acceptance and registered read response
module axi_read_channel #(
	parameter int addr_width = 5
)
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,

	// Read address channel
	input logic [addr_width-1:0] araddr,
	input logic arvalid,
	output logic arready,

	// Read data channel
	output axi_lite_pkg::word_t rdata,
	output axi_lite_pkg::resp_t rresp,
	output logic rvalid,
	input logic rready,

	// Lookup in the register bank
	output debug_regs_pkg::reg_index_t rd_index,
	input axi_lite_pkg::word_t rd_data
);
	import axi_lite_pkg::*;
	import debug_regs_pkg::*;

	// Number of address bits that select a word
	localparam int index_bits = $bits(reg_index_t);

	// New address taken only while nothing is in flight
	logic start;

	assign start = arvalid && !arready && !rvalid;

	// ----------------------------------------------------------------------
	// Address acceptance
	// ----------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			arready <= 1'b0;
		else
			arready <= start;
	end

	// Index held for the bank lookup during the ready cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (start)
			rd_index <= araddr[addr_lsb +: index_bits];
	end

	// ----------------------------------------------------------------------
	// Read response
	// ----------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rvalid <= 1'b0;
			rdata <= '0;
		end
		else if (arready)
		begin
			// Bank word captured as the address handshake ends
			rvalid <= 1'b1;
			rdata <= rd_data;
		end
		else if (rready)
			rvalid <= 1'b0;   // data stays put until the next read
	end

	// Every read completes normally
	assign rresp = resp_okay;

endmodule

`default_nettype wire

//--- verilog/axis_debugger_controlregs.sv
`timescale 1ns/1ps
`default_nettype none

// Control register block of the AXI-Stream debugger
module axis_debugger_controlregs #(
	parameter int addr_width = 5
)
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,

	// Write address channel
	input logic [addr_width-1:0] S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,

	// Write data channel
	input axi_lite_pkg::word_t S_AXI_WDATA,
	input axi_lite_pkg::strb_t S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,

	// Write response channel
	output axi_lite_pkg::resp_t S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,

	// Read address channel
	input logic [addr_width-1:0] S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,

	// Read data channel
	output axi_lite_pkg::word_t S_AXI_RDATA,
	output axi_lite_pkg::resp_t S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,

	// Status from the stream monitor
	input axi_lite_pkg::word_t byte_count,
	input axi_lite_pkg::word_t tlast_count,
	input axi_lite_pkg::word_t last_tlast
);
	import axi_lite_pkg::*;
	import debug_regs_pkg::*;

	// Write path into the bank
	reg_write_if wr_if ();

	// Read lookup between read channel and bank
	reg_index_t rd_index;
	word_t rd_data;

	// ----------------------------------------------------------------------
	// Bus side and storage
	// ----------------------------------------------------------------------

	axi_write_channel #(
		.addr_width(addr_width)
	)
	axi_write_channel_i
	(
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.awaddr(S_AXI_AWADDR),
		.awvalid(S_AXI_AWVALID),
		.awready(S_AXI_AWREADY),
		.wdata(S_AXI_WDATA),
		.wstrb(S_AXI_WSTRB),
		.wvalid(S_AXI_WVALID),
		.wready(S_AXI_WREADY),
		.bresp(S_AXI_BRESP),
		.bvalid(S_AXI_BVALID),
		.bready(S_AXI_BREADY),
		.wr(wr_if.source)
	);

	debug_reg_bank debug_reg_bank_i
	(
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr(wr_if.sink),
		.byte_count(byte_count),
		.tlast_count(tlast_count),
		.last_tlast(last_tlast),
		.rd_index(rd_index),
		.rd_data(rd_data)
	);

	axi_read_channel #(
		.addr_width(addr_width)
	)
	axi_read_channel_i
	(
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.araddr(S_AXI_ARADDR),
		.arvalid(S_AXI_ARVALID),
		.arready(S_AXI_ARREADY),
		.rdata(S_AXI_RDATA),
		.rresp(S_AXI_RRESP),
		.rvalid(S_AXI_RVALID),
		.rready(S_AXI_RREADY),
		.rd_index(rd_index),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

//--- tests/axis_debugger_controlregs_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// AXI4-Lite protocol properties on the slave port
module axis_debugger_controlregs_assertions
(
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic S_AXI_AWREADY,
	input logic S_AXI_WREADY,
	input logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input axi_lite_pkg::resp_t S_AXI_BRESP,
	input logic S_AXI_ARREADY,
	input logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	input axi_lite_pkg::word_t S_AXI_RDATA,
	input axi_lite_pkg::resp_t S_AXI_RRESP
);
	import axi_lite_pkg::*;

	// Failed assertions, collected by the testbench
	int failures = 0;

	// Address and data accepted together
	ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY == S_AXI_WREADY)
		else begin failures++; $error("awready and wready differ"); end

	// Write response held until taken
	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID && $stable(S_AXI_BRESP))
		else begin failures++; $error("write response dropped before bready"); end

	// Read data held until taken
	r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
		else begin failures++; $error("read data changed before rready"); end

	// No new read address while data is pending
	ar_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(S_AXI_ARREADY && S_AXI_RVALID))
		else begin failures++; $error("arready raised while rvalid high"); end

	// Every response is OKAY
	b_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID |-> S_AXI_BRESP == resp_okay)
		else begin failures++; $error("write response not OKAY"); end
	r_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID |-> S_AXI_RRESP == resp_okay)
		else begin failures++; $error("read response not OKAY"); end

endmodule

bind axis_debugger_controlregs axis_debugger_controlregs_assertions assertions_i
(
	.S_AXI_ACLK(S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.S_AXI_AWREADY(S_AXI_AWREADY),
	.S_AXI_WREADY(S_AXI_WREADY),
	.S_AXI_BVALID(S_AXI_BVALID),
	.S_AXI_BREADY(S_AXI_BREADY),
	.S_AXI_BRESP(S_AXI_BRESP),
	.S_AXI_ARREADY(S_AXI_ARREADY),
	.S_AXI_RVALID(S_AXI_RVALID),
	.S_AXI_RREADY(S_AXI_RREADY),
	.S_AXI_RDATA(S_AXI_RDATA),
	.S_AXI_RRESP(S_AXI_RRESP)
);

`default_nettype wire

//--- tests/tb_axis_debugger_controlregs.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axis_debugger_controlregs;
	import axi_lite_pkg::*;
	import debug_regs_pkg::*;

	// Two spare address bits above the index so aliases exist
	localparam int addr_width = 7;
	// Clock cycles allowed for any single handshake
	localparam int wait_limit = 50;

	logic clk;
	logic resetn;
	logic [addr_width-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	word_t wdata, rdata;
	strb_t wstrb;
	resp_t bresp, rresp;
	// Status words from the stream monitor side
	word_t byte_count, tlast_count, last_tlast;

	// Expected scratch contents, status entries unused
	word_t model [reg_count];
	integer seed;
	int errors;
	int test_errors;
	int tests;

	axis_debugger_controlregs #(
		.addr_width(addr_width)
	)
	axis_debugger_controlregs_i
	(
		.S_AXI_ACLK(clk),
		.S_AXI_ARESETN(resetn),
		.S_AXI_AWADDR(awaddr),
		.S_AXI_AWVALID(awvalid),
		.S_AXI_AWREADY(awready),
		.S_AXI_WDATA(wdata),
		.S_AXI_WSTRB(wstrb),
		.S_AXI_WVALID(wvalid),
		.S_AXI_WREADY(wready),
		.S_AXI_BRESP(bresp),
		.S_AXI_BVALID(bvalid),
		.S_AXI_BREADY(bready),
		.S_AXI_ARADDR(araddr),
		.S_AXI_ARVALID(arvalid),
		.S_AXI_ARREADY(arready),
		.S_AXI_RDATA(rdata),
		.S_AXI_RRESP(rresp),
		.S_AXI_RVALID(rvalid),
		.S_AXI_RREADY(rready),
		.byte_count(byte_count),
		.tlast_count(tlast_count),
		.last_tlast(last_tlast)
	);

	// 8 ns clock
	initial
		clk = 1'b0;
	always #4 clk = ~clk;

	// ----------------------------------------------------------------------
	// Compare and report helpers
	// ----------------------------------------------------------------------

	task automatic check_data(input string name, input word_t exp, input word_t act);
		if (exp !== act)
		begin
			$display("error %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_resp(input string name, input resp_t exp, input resp_t act);
		if (exp !== act)
		begin
			$display("error %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
	endtask

	// One line per finished test
	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s done with %0d errors", tests, name, errors - test_errors);
		test_errors = errors;
	endtask

	// ----------------------------------------------------------------------
	// Register model
	// ----------------------------------------------------------------------

	// Byte lane merge as the strobes describe it
	function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
		word_t w;
		w = old;
		for (int b = 0; b < strb_width; b++)
		begin
			if (strb[b])
				w[b*8 +: 8] = data[b*8 +: 8];
		end
		return w;
	endfunction

	// Word index carried by a byte address
	function automatic reg_index_t index_of(input logic [addr_width-1:0] addr);
		return reg_index_t'(addr >> addr_lsb);
	endfunction

	// Status words come live from the inputs
	function automatic word_t expected_word(input reg_index_t idx);
		if (idx == idx_byte_count)
			return byte_count;
		else if (idx == idx_tlast_count)
			return tlast_count;
		else if (idx == idx_last_tlast)
			return last_tlast;
		return model[idx];
	endfunction

	// Byte address of a word, optionally with random byte offset and upper bits
	function automatic logic [addr_width-1:0] make_addr(input int idx, input bit aliased);
		logic [addr_width-1:0] a;
		a = '0;
		if (aliased)
			a = $random(seed);
		a[addr_lsb +: $bits(reg_index_t)] = reg_index_t'(idx);
		return a;
	endfunction

	// ----------------------------------------------------------------------
	// Bus tasks, entered and left on a falling edge
	// ----------------------------------------------------------------------

	task automatic bus_write(input logic [addr_width-1:0] addr, input word_t data,
		input strb_t strb);
		int t;
		int hold;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		t = 0;
		// Ready seen at a falling edge means transfer on the next rising edge
		while (!(awready && wready) && t < wait_limit)
		begin
			@(negedge clk);
			t++;
		end
		if (!(awready && wready))
			report_timeout("write address and data ready");
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		// Random response back-pressure
		hold = {$random(seed)} % 4;
		repeat (hold) @(negedge clk);
		bready = 1'b1;
		t = 0;
		while (!bvalid && t < wait_limit)
		begin
			@(negedge clk);
			t++;
		end
		if (!bvalid)
			report_timeout("write response valid");
		else
			check_resp("S_AXI_BRESP", resp_okay, bresp);
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic bus_read(input logic [addr_width-1:0] addr, output word_t data);
		int t;
		int hold;
		araddr = addr;
		arvalid = 1'b1;
		t = 0;
		while (!arready && t < wait_limit)
		begin
			@(negedge clk);
			t++;
		end
		if (!arready)
			report_timeout("read address ready");
		@(negedge clk);
		arvalid = 1'b0;
		hold = {$random(seed)} % 4;
		repeat (hold) @(negedge clk);
		rready = 1'b1;
		t = 0;
		while (!rvalid && t < wait_limit)
		begin
			@(negedge clk);
			t++;
		end
		if (!rvalid)
			report_timeout("read data valid");
		else
			check_resp("S_AXI_RRESP", resp_okay, rresp);
		// Data is stable while rvalid waits for rready
		data = rdata;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// Write on the bus and follow it in the model
	task automatic write_update(input logic [addr_width-1:0] addr, input word_t data,
		input strb_t strb);
		bus_write(addr, data, strb);
		if (index_of(addr) >= first_scratch)
			model[index_of(addr)] = merge_bytes(model[index_of(addr)], data, strb);
	endtask

	task automatic read_check(input logic [addr_width-1:0] addr);
		word_t data;
		bus_read(addr, data);
		check_data("S_AXI_RDATA", expected_word(index_of(addr)), data);
	endtask

	task automatic new_status();
		byte_count = $random(seed);
		tlast_count = $random(seed);
		last_tlast = $random(seed);
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------

	initial
	begin
		int idx;
		seed = 99;
		errors = 0;
		test_errors = 0;
		tests = 0;
		resetn = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		new_status();
		for (int i = 0; i < reg_count; i++)
			model[i] = '0;
		repeat (8) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);

		// Scratch zero, status live
		for (int i = 0; i < reg_count; i++)
			read_check(make_addr(i, 1'b0));
		finish_test("reset values");

		repeat (12)
		begin
			idx = first_scratch + {$random(seed)} % 5;
			write_update(make_addr(idx, 1'b0), $random(seed), 4'hf);
			read_check(make_addr(idx, 1'b0));
		end
		finish_test("full word writes");

		repeat (16)
		begin
			idx = first_scratch + {$random(seed)} % 5;
			write_update(make_addr(idx, 1'b0), $random(seed), $random(seed));
			read_check(make_addr(idx, 1'b0));
		end
		finish_test("strobed writes");

		// Status words ignore writes and follow their inputs
		for (int i = 0; i < first_scratch; i++)
			write_update(make_addr(i, 1'b0), $random(seed), 4'hf);
		// Scratch words untouched by those writes
		for (int i = 0; i < reg_count; i++)
			read_check(make_addr(i, 1'b0));
		new_status();
		for (int i = 0; i < first_scratch; i++)
			read_check(make_addr(i, 1'b0));
		finish_test("status words");

		repeat (12)
		begin
			idx = {$random(seed)} % reg_count;
			write_update(make_addr(idx, 1'b1), $random(seed), $random(seed));
			read_check(make_addr(idx, 1'b1));
		end
		finish_test("address aliasing");

		// Mixed traffic with random back-pressure
		repeat (40)
		begin
			idx = {$random(seed)} % reg_count;
			if ($random(seed) & 1)
				write_update(make_addr(idx, 1'b1), $random(seed), $random(seed));
			else
				read_check(make_addr(idx, 1'b1));
		end
		finish_test("random traffic");

		errors += axis_debugger_controlregs_i.assertions_i.failures;
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
verilog/axi_lite_pkg.sv
verilog/debug_regs_pkg.sv
verilog/reg_write_if.sv
verilog/axi_write_channel.sv
verilog/debug_reg_bank.sv
verilog/axi_read_channel.sv
verilog/axis_debugger_controlregs.sv
tests/axis_debugger_controlregs_assertions.sv
tests/tb_axis_debugger_controlregs.sv
